/* list.f */
rtl/merge_config_pkg.sv
rtl/merge_packet_pkg.sv
rtl/packet_fifo.sv
rtl/merge_config_memory.sv
rtl/merge_generator.sv
rtl/engine_merge_data.sv
tb/tb_clock_gen.sv
tb/tb_engine_merge_data.sv

/* rtl/engine_merge_data.sv */
module engine_merge_data
    import merge_packet_pkg::*;
    import merge_config_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_csr_engine,
    input  descriptor_t  descriptor_in,
    input  mem_packet_t  response_memory_in,
    input  mem_packet_t  response_engine_in [MERGE_LANES],
    input  logic         request_engine_out_ready,
    output mem_packet_t  request_engine_out,
    output fifo_status_t response_memory_status,
    output fifo_status_t response_engine_status [MERGE_LANES],
    output logic         done_out
);

    descriptor_t            descriptor_reg;
    mem_packet_t            response_memory_reg;
    mem_packet_t            response_engine_reg [MERGE_LANES];
    logic                   ready_reg;

    mem_packet_t            memory_fifo_out;
    fifo_status_t           memory_fifo_status;
    logic                   memory_pop;

    mem_packet_t            lane_fifo_out [MERGE_LANES];
    fifo_status_t           lane_fifo_status [MERGE_LANES];
    logic [MERGE_LANES-1:0] lane_pop;

    merge_config_t          config_held;
    logic                   config_ready;

    mem_packet_t            generator_request;
    logic                   generator_done;

    mem_packet_t            request_fifo_out;
    fifo_status_t           request_fifo_status;
    logic                   request_pop;

    // -------------------------------------------------------------------------
    // Input registers
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        descriptor_reg      <= descriptor_in;
        response_memory_reg <= response_memory_in;
        response_engine_reg <= response_engine_in;
        ready_reg           <= request_engine_out_ready;
        if (areset_csr_engine) begin
            descriptor_reg.valid      <= 1'b0;
            response_memory_reg.valid <= 1'b0;
            ready_reg                 <= 1'b0;
            for (int i = 0; i < MERGE_LANES; i++) begin
                response_engine_reg[i].valid <= 1'b0;
            end
        end
    end

    // -------------------------------------------------------------------------
    // Output registers
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        request_engine_out     <= request_fifo_out;
        response_memory_status <= memory_fifo_status;
        response_engine_status <= lane_fifo_status;
        done_out               <= generator_done;
        if (areset_csr_engine) begin
            request_engine_out.valid <= 1'b0;
            response_memory_status   <= FIFO_STATUS_RESET;
            done_out                 <= 1'b1;
            for (int i = 0; i < MERGE_LANES; i++) begin
                response_engine_status[i] <= FIFO_STATUS_RESET;
            end
        end
    end

    // -------------------------------------------------------------------------
    // Memory response FIFO, drained into the configuration block
    // -------------------------------------------------------------------------
    assign memory_pop = ~memory_fifo_status.empty;

    packet_fifo inst_memory_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .wr_en            (response_memory_reg.valid),
        .din              (response_memory_reg.payload),
        .rd_en            (memory_pop),
        .dout             (memory_fifo_out.payload),
        .valid            (memory_fifo_out.valid),
        .status           (memory_fifo_status)
    );

    merge_config_memory inst_config_memory (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .response_memory_in(memory_fifo_out),
        .config_out        (config_held),
        .config_ready      (config_ready)
    );

    // -------------------------------------------------------------------------
    // Lane FIFOs, popped only by the generator
    // -------------------------------------------------------------------------
    for (genvar i = 0; i < MERGE_LANES; i++) begin : gen_lane_fifo
        packet_fifo inst_lane_fifo (
            .ap_clk           (ap_clk),
            .areset_csr_engine(areset_csr_engine),
            .wr_en            (response_engine_reg[i].valid),
            .din              (response_engine_reg[i].payload),
            .rd_en            (lane_pop[i]),
            .dout             (lane_fifo_out[i].payload),
            .valid            (lane_fifo_out[i].valid),
            .status           (lane_fifo_status[i])
        );
    end

    merge_generator inst_generator (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .descriptor_in    (descriptor_reg),
        .config_in        (config_held),
        .config_ready     (config_ready),
        .lane_packet      (lane_fifo_out),
        .lane_status      (lane_fifo_status),
        .lane_pop         (lane_pop),
        .out_full         (request_fifo_status.prog_full),
        .request_out      (generator_request),
        .done             (generator_done)
    );

    // -------------------------------------------------------------------------
    // Request FIFO towards the outside
    // -------------------------------------------------------------------------
    assign request_pop = ready_reg & ~request_fifo_status.empty;

    packet_fifo inst_request_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .wr_en            (generator_request.valid),
        .din              (generator_request.payload),
        .rd_en            (request_pop),
        .dout             (request_fifo_out.payload),
        .valid            (request_fifo_out.valid),
        .status           (request_fifo_status)
    );

endmodule : engine_merge_data

/* rtl/merge_config_memory.sv */
module merge_config_memory
    import merge_packet_pkg::*;
    import merge_config_pkg::*;
(
    input  logic          ap_clk,
    input  logic          areset_csr_engine,
    input  mem_packet_t   response_memory_in,
    output merge_config_t config_out,
    output logic          config_ready
);

    config_word_t cfg_word;
    logic         seen_mask;
    logic         seen_op;

    // Memory responses are read as configuration words
    assign cfg_word     = response_memory_in.payload.data.cfg;
    assign config_ready = seen_mask & seen_op;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            config_out <= '{lane_mask: '0, merge_op: MERGE_SUM};
            seen_mask  <= 1'b0;
            seen_op    <= 1'b0;
        end else if (response_memory_in.valid) begin
            case (cfg_word.cfg_index)
                CFG_INDEX_MASK: begin
                    config_out.lane_mask <= cfg_word.cfg_value[MERGE_LANES-1:0];
                    seen_mask            <= 1'b1;
                end
                CFG_INDEX_OP: begin
                    config_out.merge_op <=
                        merge_op_e'(cfg_word.cfg_value[$bits(merge_op_e)-1:0]);
                    seen_op             <= 1'b1;
                end
                // Unknown index, held configuration stays as it is
                default: ;
            endcase
        end
    end

endmodule : merge_config_memory

/* rtl/merge_config_pkg.sv */
package merge_config_pkg;

    // -------------------------------------------------------------------------
    // Engine shape and buffering
    // -------------------------------------------------------------------------
    localparam int MERGE_LANES = 2;
    localparam int FIFO_DEPTH  = 32;
    localparam int PROG_THRESH = 16;
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W  = FIFO_PTR_W + 1;

    // -------------------------------------------------------------------------
    // Configuration word carried in memory responses
    // -------------------------------------------------------------------------
    localparam int CFG_INDEX_W = 4;
    localparam int CFG_VALUE_W = 28;

    localparam logic [CFG_INDEX_W-1:0] CFG_INDEX_MASK = 4'd0;
    localparam logic [CFG_INDEX_W-1:0] CFG_INDEX_OP   = 4'd1;

    typedef struct packed {
        logic [CFG_INDEX_W-1:0] cfg_index;
        logic [CFG_VALUE_W-1:0] cfg_value;
    } config_word_t;

    typedef enum logic [1:0] {
        MERGE_SUM = 2'd0,
        MERGE_MAX = 2'd1
    } merge_op_e;

    // Held configuration, one mask bit per lane
    typedef struct packed {
        logic [MERGE_LANES-1:0] lane_mask;
        merge_op_e              merge_op;
    } merge_config_t;

endpackage : merge_config_pkg

/* rtl/merge_generator.sv */
module merge_generator
    import merge_packet_pkg::*;
    import merge_config_pkg::*;
(
    input  logic                   ap_clk,
    input  logic                   areset_csr_engine,
    input  descriptor_t            descriptor_in,
    input  merge_config_t          config_in,
    input  logic                   config_ready,
    input  mem_packet_t            lane_packet [MERGE_LANES],
    input  fifo_status_t           lane_status [MERGE_LANES],
    output logic [MERGE_LANES-1:0] lane_pop,
    input  logic                   out_full,
    output mem_packet_t            request_out,
    output logic                   done
);

    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_POP,
        GEN_MERGE
    } gen_state_e;

    gen_state_e         state;
    merge_config_t      job_cfg;
    logic [COUNT_W-1:0] job_count;
    logic [ADDR_W-1:0]  job_base;
    logic [COUNT_W-1:0] pop_idx;
    logic [COUNT_W-1:0] merge_idx;
    logic               pop_pending;
    logic               lanes_ready;
    logic               job_start;
    logic               pop_fire;
    logic               merge_fire;
    logic [DATA_W-1:0]  merged;

    assign job_start = (state == GEN_IDLE) & descriptor_in.valid & config_ready
                     & (descriptor_in.packet_count != '0);

    // Every enabled lane must hold a packet before a step is popped
    always_comb begin
        lanes_ready = 1'b1;
        for (int i = 0; i < MERGE_LANES; i++) begin
            if (job_cfg.lane_mask[i] && lane_status[i].empty) begin
                lanes_ready = 1'b0;
            end
        end
    end

    assign pop_fire   = (state == GEN_POP) & lanes_ready & ~out_full;
    assign lane_pop   = {MERGE_LANES{pop_fire}} & job_cfg.lane_mask;
    assign merge_fire = pop_pending;

    // Sum wraps at 32 bits, max is unsigned
    always_comb begin
        merged = '0;
        for (int i = 0; i < MERGE_LANES; i++) begin
            if (job_cfg.lane_mask[i] && lane_packet[i].valid) begin
                if (job_cfg.merge_op == MERGE_MAX) begin
                    if (lane_packet[i].payload.data.value > merged) begin
                        merged = lane_packet[i].payload.data.value;
                    end
                end else begin
                    merged = merged + lane_packet[i].payload.data.value;
                end
            end
        end
    end

    // -------------------------------------------------------------------------
    // Job FSM
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state       <= GEN_IDLE;
            pop_idx     <= '0;
            merge_idx   <= '0;
            pop_pending <= 1'b0;
            done        <= 1'b1;
        end else begin
            pop_pending <= pop_fire;
            if (merge_fire) begin
                merge_idx <= merge_idx + 1'b1;
            end
            case (state)
                GEN_IDLE: begin
                    if (job_start) begin
                        state     <= GEN_POP;
                        pop_idx   <= '0;
                        merge_idx <= '0;
                        done      <= 1'b0;
                    end
                end
                GEN_POP: begin
                    if (pop_fire) begin
                        pop_idx <= pop_idx + 1'b1;
                        if (pop_idx == job_count - 1'b1) begin
                            state <= GEN_MERGE;
                        end
                    end
                end
                GEN_MERGE: begin
                    // Last step's data arrives one cycle after its pop
                    if (merge_fire && (merge_idx == job_count - 1'b1)) begin
                        state <= GEN_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= GEN_IDLE;
            endcase
        end
    end

    // Job parameters are frozen for the whole run
    always_ff @(posedge ap_clk) begin
        if (job_start) begin
            job_cfg   <= config_in;
            job_count <= descriptor_in.packet_count;
            job_base  <= descriptor_in.base_address;
        end
    end

    // -------------------------------------------------------------------------
    // Merged request
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        request_out.valid              <= merge_fire;
        request_out.payload.id         <= merge_idx[ID_W-1:0];
        request_out.payload.address    <= job_base + ADDR_W'({merge_idx, 2'b00});
        request_out.payload.data.value <= merged;
        if (areset_csr_engine) begin
            request_out.valid <= 1'b0;
        end
    end

endmodule : merge_generator

/* rtl/merge_packet_pkg.sv */
package merge_packet_pkg;
    import merge_config_pkg::*;

    // -------------------------------------------------------------------------
    // Field widths
    // -------------------------------------------------------------------------
    localparam int DATA_W  = 32;
    localparam int ADDR_W  = 32;
    localparam int ID_W    = 8;
    localparam int COUNT_W = 16;

    // Lane packets carry a value, memory responses carry configuration
    typedef union packed {
        logic [DATA_W-1:0] value;
        config_word_t      cfg;
    } data_word_u;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] address;
        data_word_u        data;
    } packet_payload_t;

    typedef struct packed {
        logic            valid;
        packet_payload_t payload;
    } mem_packet_t;

    typedef struct packed {
        logic               valid;
        logic [COUNT_W-1:0] packet_count;
        logic [ADDR_W-1:0]  base_address;
    } descriptor_t;

    typedef struct packed {
        logic empty;
        logic full;
        logic prog_full;
    } fifo_status_t;

    // Status seen by the outside while in reset
    localparam fifo_status_t FIFO_STATUS_RESET = '{empty: 1'b1, full: 1'b0, prog_full: 1'b0};

endpackage : merge_packet_pkg

/* rtl/packet_fifo.sv */
module packet_fifo
    import merge_packet_pkg::*;
    import merge_config_pkg::*;
(
    input  logic            ap_clk,
    input  logic            areset_csr_engine,
    input  logic            wr_en,
    input  packet_payload_t din,
    input  logic            rd_en,
    output packet_payload_t dout,
    output logic            valid,
    output fifo_status_t    status
);

    packet_payload_t       mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  push;
    logic                  pop;

    // Writes when full and reads when empty are dropped
    assign push = wr_en & ~status.full;
    assign pop  = rd_en & ~status.empty;

    assign status.empty     = (count == '0);
    assign status.full      = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign status.prog_full = (count >= FIFO_CNT_W'(PROG_THRESH));

    // -------------------------------------------------------------------------
    // Pointers and fill level
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= pop;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // -------------------------------------------------------------------------
    // Storage and read data
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
        // Data lands one cycle after the pop, together with valid
        if (pop) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule : packet_fifo

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -j 0 -f list.f \
    --top-module tb_engine_merge_data -o tb_engine_merge_data \
    && ./obj_dir/tb_engine_merge_data | tee /dev/stderr | grep -q "TEST PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

/* tb/tb_clock_gen.sv */
module tb_clock_gen (
    output logic ap_clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    initial begin
        ap_clk = 1'b0;
        forever begin
            #50 ap_clk = ~ap_clk;
        end
    end

endmodule : tb_clock_gen

/* tb/tb_engine_merge_data.sv */
module tb_engine_merge_data
    import merge_packet_pkg::*;
    import merge_config_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        merge_op_e              op;
        logic [MERGE_LANES-1:0] mask;
        logic [15:0]            count;
        logic [31:0]            base;
        logic [31:0]            ready;
        logic                   junk_cfg;
        logic [3:0]             stray;
    } job_row_t;

    localparam int NUM_JOBS = 5;
    // op, lane mask, count, base address, ready pattern, unknown cfg index, stray words
    localparam job_row_t JOBS [NUM_JOBS] = '{
        '{MERGE_SUM, 2'b11, 16'd8,  32'h1000_0000, 32'hFFFF_FFFF, 1'b0, 4'd0},
        '{MERGE_MAX, 2'b01, 16'd6,  32'h2000_0100, 32'hFFFF_FFFF, 1'b0, 4'd3},
        '{MERGE_MAX, 2'b11, 16'd12, 32'h4000_0040, 32'hF0F0_F0F0, 1'b0, 4'd0},
        '{MERGE_MAX, 2'b11, 16'd5,  32'h2000_0800, 32'h5555_5555, 1'b1, 4'd0},
        '{MERGE_SUM, 2'b11, 16'd40, 32'h3000_0000, 32'h0000_000F, 1'b0, 4'd0}
    };
    localparam fifo_status_t EMPTY_STATUS = '{empty: 1'b1, full: 1'b0, prog_full: 1'b0};

    logic            ap_clk;
    logic            areset_csr_engine;
    descriptor_t     descriptor_in;
    mem_packet_t     response_memory_in;
    mem_packet_t     response_engine_in [MERGE_LANES];
    logic            request_engine_out_ready;
    mem_packet_t     request_engine_out;
    fifo_status_t    response_memory_status;
    fifo_status_t    response_engine_status [MERGE_LANES];
    logic            done_out;

    int              errors = 0;
    logic [31:0]     lcg_state = 32'hb000d5eb;
    logic [31:0]     ready_pattern = '0;
    logic [31:0]     feed_q [MERGE_LANES][$];
    logic [31:0]     lane_model [MERGE_LANES][$];
    packet_payload_t exp_q [$];

    tb_clock_gen inst_clock (.ap_clk(ap_clk));

    engine_merge_data dut (
        .ap_clk                  (ap_clk),
        .areset_csr_engine       (areset_csr_engine),
        .descriptor_in           (descriptor_in),
        .response_memory_in      (response_memory_in),
        .response_engine_in      (response_engine_in),
        .request_engine_out_ready(request_engine_out_ready),
        .request_engine_out      (request_engine_out),
        .response_memory_status  (response_memory_status),
        .response_engine_status  (response_engine_status),
        .done_out                (done_out)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic send_config(input logic [3:0] idx, input logic [27:0] val);
        mem_packet_t pkt;
        pkt = '0;
        pkt.valid = 1'b1;
        pkt.payload.data.cfg.cfg_index = idx;
        pkt.payload.data.cfg.cfg_value = val;
        @(posedge ap_clk);
        response_memory_in <= pkt;
        @(posedge ap_clk);
        response_memory_in <= '0;
    endtask

    // One word per lane per cycle, held back while the lane reports prog_full
    task automatic feed_lanes();
        mem_packet_t pkt;
        logic        busy;
        busy = 1'b1;
        while (busy) begin
            @(posedge ap_clk);
            busy = 1'b0;
            for (int l = 0; l < MERGE_LANES; l++) begin
                pkt = '0;
                if (feed_q[l].size() > 0 && !response_engine_status[l].prog_full) begin
                    pkt.valid = 1'b1;
                    pkt.payload.data.value = feed_q[l].pop_front();
                end
                response_engine_in[l] <= pkt;
                if (feed_q[l].size() > 0) begin
                    busy = 1'b1;
                end
            end
        end
        @(posedge ap_clk);
        for (int l = 0; l < MERGE_LANES; l++) begin
            response_engine_in[l] <= '0;
        end
    endtask

    task automatic wait_job_done(input int count);
        int waited;
        waited = 0;
        while (done_out && waited < 16) begin
            @(negedge ap_clk);
            waited++;
        end
        assert (!done_out) else begin
            errors++;
            $display("done_out did not fall after the descriptor was sent");
        end
        waited = 0;
        while ((!done_out || exp_q.size() != 0) && waited < count * 64 + 200) begin
            @(negedge ap_clk);
            waited++;
        end
        assert (done_out && exp_q.size() == 0) else begin
            errors++;
            $display("Job timed out with done_out %0b and %0d requests missing",
                     done_out, exp_q.size());
        end
    endtask

    task automatic check_request();
        packet_payload_t exp;
        assert (exp_q.size() != 0) else begin
            errors++;
            $display("Request for address %h arrived when none was expected",
                     request_engine_out.payload.address);
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            assert (request_engine_out.payload.id == exp.id) else begin
                errors++;
                $display("Mismatch request_engine_out.payload.id: got %h expected %h",
                         request_engine_out.payload.id, exp.id);
            end
            assert (request_engine_out.payload.address == exp.address) else begin
                errors++;
                $display("Mismatch request_engine_out.payload.address: got %h expected %h",
                         request_engine_out.payload.address, exp.address);
            end
            assert (request_engine_out.payload.data.value == exp.data.value) else begin
                errors++;
                $display("Mismatch request_engine_out.payload.data: got %h expected %h",
                         request_engine_out.payload.data.value, exp.data.value);
            end
            // Last request of a job only leaves after done_out has risen
            assert (exp_q.size() != 0 || done_out) else begin
                errors++;
                $display("done_out was still low when the last request came out");
            end
        end
    endtask

    // Fill flags follow the words still held in each lane
    task automatic check_lane_status();
        fifo_status_t exp_status;
        for (int l = 0; l < MERGE_LANES; l++) begin
            exp_status.empty     = (lane_model[l].size() == 0);
            exp_status.full      = (lane_model[l].size() >= FIFO_DEPTH);
            exp_status.prog_full = (lane_model[l].size() >= PROG_THRESH);
            assert (response_engine_status[l] == exp_status) else begin
                errors++;
                $display("Mismatch response_engine_status[%0d]: got %h expected %h",
                         l, response_engine_status[l], exp_status);
            end
        end
    endtask

    task automatic check_memory_status();
        assert (response_memory_status == EMPTY_STATUS) else begin
            errors++;
            $display("Mismatch response_memory_status: got %h expected %h",
                     response_memory_status, EMPTY_STATUS);
        end
    endtask

    task automatic run_job(input job_row_t job);
        logic [31:0]     word;
        logic [31:0]     merged;
        packet_payload_t exp;
        if (job.junk_cfg) begin
            send_config(4'hF, 28'h000_0002);
        end else begin
            send_config(CFG_INDEX_MASK, 28'(job.mask));
            send_config(CFG_INDEX_OP, 28'(job.op));
        end
        repeat (4) @(posedge ap_clk);
        ready_pattern = job.ready;
        // Stray words go to lanes outside the mask and should stay there
        for (int n = 0; n < int'(job.stray); n++) begin
            for (int l = 0; l < MERGE_LANES; l++) begin
                if (!job.mask[l]) begin
                    lcg_state = lcg_step(lcg_state);
                    feed_q[l].push_back(lcg_state);
                    lane_model[l].push_back(lcg_state);
                end
            end
        end
        for (int s = 0; s < int'(job.count); s++) begin
            for (int l = 0; l < MERGE_LANES; l++) begin
                if (job.mask[l]) begin
                    lcg_state = lcg_step(lcg_state);
                    feed_q[l].push_back(lcg_state);
                    lane_model[l].push_back(lcg_state);
                end
            end
        end
        // Expected requests, oldest lane words first
        for (int s = 0; s < int'(job.count); s++) begin
            merged = '0;
            for (int l = 0; l < MERGE_LANES; l++) begin
                if (job.mask[l]) begin
                    word = lane_model[l].pop_front();
                    if (job.op == MERGE_MAX) begin
                        merged = (word > merged) ? word : merged;
                    end else begin
                        merged = merged + word;
                    end
                end
            end
            exp = '0;
            exp.id = 8'(s);
            exp.address = job.base + 32'(4 * s);
            exp.data.value = merged;
            exp_q.push_back(exp);
        end
        @(posedge ap_clk);
        descriptor_in <= '{valid: 1'b1, packet_count: job.count, base_address: job.base};
        @(posedge ap_clk);
        descriptor_in <= '0;
        fork
            feed_lanes();
            wait_job_done(int'(job.count));
        join
        @(negedge ap_clk);
        check_lane_status();
        check_memory_status();
    endtask

    // -------------------------------------------------------------------------
    // Output side: ready pattern and request monitor
    // -------------------------------------------------------------------------
    initial begin
        logic [4:0] phase;
        phase = '0;
        request_engine_out_ready = 1'b0;
        forever begin
            @(posedge ap_clk);
            request_engine_out_ready <= ready_pattern[phase];
            phase = phase + 5'd1;
        end
    end

    initial begin
        forever begin
            @(negedge ap_clk);
            if (!areset_csr_engine && request_engine_out.valid) begin
                check_request();
            end
        end
    end

    initial begin
        int budget;
        budget = 200;
        for (int r = 0; r < NUM_JOBS; r++) begin
            budget += int'(JOBS[r].count) * 64 + 300;
        end
        repeat (budget) @(posedge ap_clk);
        $display("Watchdog expired after %0d cycles, run stopped", budget);
        $display("TEST FAILED");
        $finish;
    end

    // -------------------------------------------------------------------------
    // Main sequence
    // -------------------------------------------------------------------------
    initial begin
        areset_csr_engine = 1'b1;
        descriptor_in = '0;
        response_memory_in = '0;
        for (int l = 0; l < MERGE_LANES; l++) begin
            response_engine_in[l] = '0;
        end
        repeat (8) @(posedge ap_clk);
        areset_csr_engine <= 1'b0;
        @(negedge ap_clk);
        assert (done_out == 1'b1 && request_engine_out.valid == 1'b0) else begin
            errors++;
            $display("Mismatch done_out/request valid after reset: got %h/%h expected 1/0",
                     done_out, request_engine_out.valid);
        end
        check_memory_status();
        check_lane_status();
        for (int r = 0; r < NUM_JOBS; r++) begin
            run_job(JOBS[r]);
        end
        repeat (4) @(posedge ap_clk);
        $display("Checks done, %0d errors, %0d requests left unseen", errors, exp_q.size());
        if (errors == 0 && exp_q.size() == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_engine_merge_data
